// ==== logic/udp_rx_settings.svh ====
`ifndef UDP_RX_SETTINGS_SVH
`define UDP_RX_SETTINGS_SVH

// payload bytes held in the display word
`define UDP_RX_CAPACITY 4

// accepted udp destination port
`define UDP_RX_PORT 16'd5000

// eth 14 + ipv4 20 + udp 8 without ip options
`define UDP_RX_HDR_BYTES 42

`endif

// ==== logic/udp_rx_pkg.sv ====
`include "udp_rx_settings.svh"

package udp_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;
    typedef logic [7:0]  drop_cnt_t;

    // display word with slot 0 in the top byte
    typedef logic [`UDP_RX_CAPACITY*8-1:0] payload_t;

    typedef enum logic [1:0] {
        ST_HEADER,  // walking the 42 header bytes
        ST_PAYLOAD, // forwarding payload
        ST_SKIP     // rejected frame waits for the end
    } parser_state_e;

endpackage : udp_rx_pkg

// ==== logic/udp_stream_if.sv ====
interface udp_stream_if;
    import udp_rx_pkg::*;

    logic  valid;
    byte_t data;
    logic  rx_end;
    logic  len_err; // only meaningful together with rx_end

    modport src (
        output valid, data, rx_end, len_err
    );

    modport snk (
        input valid, data, rx_end, len_err
    );

endinterface : udp_stream_if

// ==== logic/udp_header_parser.sv ====
`include "udp_rx_settings.svh"

module udp_header_parser (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  mac_valid,
    input  udp_rx_pkg::byte_t     mac_data,
    input  logic                  mac_end,
    output udp_rx_pkg::drop_cnt_t drops,
    udp_stream_if.src             stream
);
    import udp_rx_pkg::*;

    localparam port_t RX_PORT  = `UDP_RX_PORT;
    localparam len_t  HDR_LAST = len_t'(`UDP_RX_HDR_BYTES - 1);

    parser_state_e state;
    len_t          cnt;     // header index, then payload byte count
    len_t          udp_len; // raw length field including the 8 byte udp header
    len_t          pay_len;
    logic          hdr_ok;
    logic          field_bad;
    logic          fwd;
    drop_cnt_t     drops_next;

    assign pay_len = udp_len - len_t'(8);

    // bytes past the declared length are eth padding
    assign fwd = (state == ST_PAYLOAD) && mac_valid && (cnt < pay_len);

    assign drops_next = (drops == '1) ? drops : drops + 1'b1;

    // compare the current header byte against what it has to be
    always_comb begin
        case (cnt)
            16'd12:  field_bad = (mac_data != 8'h08); // ethertype ipv4
            16'd13:  field_bad = (mac_data != 8'h00);
            16'd23:  field_bad = (mac_data != 8'h11); // protocol udp
            16'd36:  field_bad = (mac_data != RX_PORT[15:8]);
            16'd37:  field_bad = (mac_data != RX_PORT[7:0]);
            default: field_bad = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state          <= ST_HEADER;
            cnt            <= '0;
            hdr_ok         <= 1'b1;
            drops          <= '0;
            stream.valid   <= 1'b0;
            stream.rx_end  <= 1'b0;
            stream.len_err <= 1'b0;
        end else begin
            stream.valid   <= fwd;
            stream.rx_end  <= 1'b0;
            stream.len_err <= 1'b0;
            case (state)
                ST_HEADER: begin
                    if (mac_end) begin
                        // frame cut inside the header
                        cnt    <= '0;
                        hdr_ok <= 1'b1;
                        drops  <= drops_next;
                    end else if (mac_valid) begin
                        if (cnt == HDR_LAST) begin
                            cnt   <= '0;
                            state <= hdr_ok ? ST_PAYLOAD : ST_SKIP;
                        end else begin
                            cnt <= cnt + 1'b1;
                            if (field_bad) begin
                                hdr_ok <= 1'b0;
                            end
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (mac_end) begin
                        stream.rx_end  <= 1'b1;
                        stream.len_err <= (cnt < pay_len); // came up short
                        cnt            <= '0;
                        hdr_ok         <= 1'b1;
                        state          <= ST_HEADER;
                    end else if (fwd) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                ST_SKIP: begin
                    if (mac_end) begin
                        drops  <= drops_next;
                        hdr_ok <= 1'b1;
                        state  <= ST_HEADER;
                    end
                end
                default: state <= ST_HEADER;
            endcase
        end
    end

    // payload byte and udp length capture
    always_ff @(posedge clk) begin
        if (fwd) begin
            stream.data <= mac_data;
        end
        if (state == ST_HEADER && mac_valid) begin
            if (cnt == 16'd38) begin
                udp_len[15:8] <= mac_data;
            end
            if (cnt == 16'd39) begin
                udp_len[7:0] <= mac_data;
            end
        end
    end

endmodule : udp_header_parser

// ==== logic/udp_reader.sv ====
`include "udp_rx_settings.svh"

module udp_reader #(
    parameter int CAPACITY = `UDP_RX_CAPACITY
) (
    input  logic                 clk,
    input  logic                 rstn,
    udp_stream_if.snk            stream,
    output udp_rx_pkg::payload_t o_data,
    output logic                 error,
    output logic                 trig
);
    import udp_rx_pkg::*;

    localparam int WPTR_W = (CAPACITY > 1) ? $clog2(CAPACITY) : 1;

    byte_t                  store [CAPACITY];
    logic [WPTR_W-1:0]      wptr;
    logic [CAPACITY*8-1:0]  store_word;
    logic                   all_ones;
    logic                   all_zero;

    // slot 0 lands in the top byte
    for (genvar j = 0; j < CAPACITY; j++) begin : g_flat
        assign store_word[(CAPACITY-j)*8-1 -: 8] = store[j];
    end

    assign all_ones = &store_word;
    assign all_zero = ~|store_word;

    always_ff @(posedge clk) begin
        if (stream.valid) begin
            store[wptr] <= stream.data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wptr   <= '0;
            error  <= 1'b0;
            trig   <= 1'b0;
            o_data <= '0;
        end else begin
            trig <= 1'b0; // single cycle pulse
            if (stream.valid) begin
                if (wptr == WPTR_W'(CAPACITY - 1)) begin
                    wptr <= '0;
                end else begin
                    wptr <= wptr + 1'b1;
                end
            end else if (stream.rx_end) begin
                wptr <= '0;
                if (stream.len_err) begin
                    error <= 1'b1; // truncated frame leaves the display alone
                end else begin
                    // partial last word means length not a multiple of capacity
                    error <= (wptr != '0);
                    if (all_ones) begin
                        trig <= 1'b1;
                    end else if (!all_zero) begin
                        o_data <= store_word;
                    end
                end
            end
        end
    end

endmodule : udp_reader

// ==== logic/udp_rx_top.sv ====
`include "udp_rx_settings.svh"

module udp_rx_top (
    input  logic                  clk,
    input  logic                  rstn,

    input  logic                  mac_valid,
    input  udp_rx_pkg::byte_t     mac_data,
    input  logic                  mac_end,

    output udp_rx_pkg::payload_t  o_data,
    output logic                  error,
    output logic                  trig,
    output udp_rx_pkg::drop_cnt_t drops
);

    udp_stream_if stream ();

    // mac bytes in, filtered payload stream out
    udp_header_parser u_parser (
        .clk       (clk),
        .rstn      (rstn),
        .mac_valid (mac_valid),
        .mac_data  (mac_data),
        .mac_end   (mac_end),
        .drops     (drops),
        .stream    (stream.src)
    );

    udp_reader #(
        .CAPACITY (`UDP_RX_CAPACITY)
    ) u_reader (
        .clk    (clk),
        .rstn   (rstn),
        .stream (stream.snk),
        .o_data (o_data),
        .error  (error),
        .trig   (trig)
    );

endmodule : udp_rx_top

// ==== test/udp_rx_tb.sv ====
`include "udp_rx_settings.svh"

module udp_rx_tb;
    import udp_rx_pkg::*;

    localparam int    CAP             = `UDP_RX_CAPACITY;
    localparam int    HDR             = `UDP_RX_HDR_BYTES;
    localparam port_t PORT            = `UDP_RX_PORT;
    localparam int    N_DIRECTED      = 13;
    localparam int    N_RANDOM        = 40;
    localparam int    WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 100 + 500;

    // payload fill modes
    localparam int PAY_MIXED = 0; // no byte is 0x00 or 0xff
    localparam int PAY_ONES  = 1;
    localparam int PAY_ZERO  = 2;
    localparam int PAY_ANY   = 3;

    logic      clk;
    logic      rstn;
    logic      mac_valid;
    byte_t     mac_data;
    logic      mac_end;
    payload_t  o_data;
    logic      error;
    logic      trig;
    drop_cnt_t drops;

    byte_t frame_q[$];
    byte_t pay_q[$];

    // reference model
    byte_t     m_store [CAP];
    int        m_wptr;
    payload_t  exp_o_data;
    logic      exp_error;
    logic      exp_trig;
    drop_cnt_t exp_drops;

    udp_rx_top DUT (
        .clk       (clk),
        .rstn      (rstn),
        .mac_valid (mac_valid),
        .mac_data  (mac_data),
        .mac_end   (mac_end),
        .o_data    (o_data),
        .error     (error),
        .trig      (trig),
        .drops     (drops)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the frames did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // slot 0 is the top byte of the display word
    function automatic payload_t pack_store();
        payload_t w;
        w = '0;
        for (int j = 0; j < CAP; j++) begin
            w = (w << 8) | payload_t'(m_store[j]);
        end
        return w;
    endfunction

    task automatic fill_payload(input int mode, input int len);
        pay_q.delete();
        for (int i = 0; i < len; i++) begin
            case (mode)
                PAY_MIXED: pay_q.push_back(byte_t'($urandom_range(1, 254)));
                PAY_ONES:  pay_q.push_back(8'hff);
                PAY_ZERO:  pay_q.push_back(8'h00);
                default:   pay_q.push_back(byte_t'($urandom));
            endcase
        end
    endtask

    // header fields, then pay_q, then pad bytes of eth padding
    task automatic build_frame(input logic [15:0] ethertype, input byte_t proto,
                               input port_t dport, input int declared, input int pad);
        len_t udp_len;
        udp_len = len_t'(declared + 8);
        frame_q.delete();
        for (int i = 0; i < HDR; i++) begin
            frame_q.push_back(byte_t'($urandom));
        end
        frame_q[12] = ethertype[15:8];
        frame_q[13] = ethertype[7:0];
        frame_q[14] = 8'h45; // ipv4 without options
        frame_q[23] = proto;
        frame_q[36] = dport[15:8];
        frame_q[37] = dport[7:0];
        frame_q[38] = udp_len[15:8];
        frame_q[39] = udp_len[7:0];
        foreach (pay_q[i]) begin
            frame_q.push_back(pay_q[i]);
        end
        for (int i = 0; i < pad; i++) begin
            frame_q.push_back(byte_t'($urandom));
        end
    endtask

    task automatic cut_frame(input int n);
        while (frame_q.size() > n) begin
            void'(frame_q.pop_back());
        end
    endtask

    task automatic model_frame();
        int       n;
        int       declared;
        int       fwd;
        logic     hdr_ok;
        payload_t w;
        n        = frame_q.size();
        hdr_ok   = 1'b0;
        exp_trig = 1'b0;
        if (n >= HDR) begin
            hdr_ok = (frame_q[12] == 8'h08) && (frame_q[13] == 8'h00)
                  && (frame_q[23] == 8'h11) && ({frame_q[36], frame_q[37]} == PORT);
        end
        if (!hdr_ok) begin
            if (exp_drops != 8'hff) begin
                exp_drops = exp_drops + 8'd1;
            end
        end else begin
            declared = int'({frame_q[38], frame_q[39]}) - 8;
            fwd      = 0;
            for (int i = HDR; i < n && fwd < declared; i++) begin
                m_store[m_wptr] = frame_q[i];
                m_wptr          = (m_wptr + 1) % CAP;
                fwd++;
            end
            if (fwd < declared) begin
                exp_error = 1'b1; // payload came up short
            end else begin
                exp_error = (m_wptr != 0);
                w         = pack_store();
                if (&w) begin
                    exp_trig = 1'b1;
                end else if (|w) begin
                    exp_o_data = w;
                end
            end
            m_wptr = 0;
        end
    endtask

    task automatic check_results();
        expect_equal("o_data", 64'(o_data), 64'(exp_o_data));
        expect_equal("error", 64'(error), 64'(exp_error));
        expect_equal("trig", 64'(trig), 64'(exp_trig));
        expect_equal("drops", 64'(drops), 64'(exp_drops));
    endtask

    task automatic send_and_check();
        model_frame();
        foreach (frame_q[i]) begin
            @(negedge clk);
            mac_valid = 1'b1;
            mac_data  = frame_q[i];
        end
        @(negedge clk);
        mac_valid = 1'b0;
        mac_data  = '0;
        mac_end   = 1'b1;
        @(negedge clk);
        mac_end = 1'b0;
        @(negedge clk); // two cycles after mac_end
        check_results();
        @(negedge clk);
        expect_equal("trig", 64'(trig), 64'(1'b0)); // pulse is one cycle wide
        repeat ($urandom_range(1, 4)) @(negedge clk);
    endtask

    initial begin : stimulus
        int kind;
        int len;
        void'($urandom(32'h7f510327));
        rstn       = 1'b0;
        mac_valid  = 1'b0;
        mac_data   = '0;
        mac_end    = 1'b0;
        m_wptr     = 0;
        exp_o_data = '0;
        exp_error  = 1'b0;
        exp_trig   = 1'b0;
        exp_drops  = '0;
        for (int j = 0; j < CAP; j++) begin
            m_store[j] = 8'h00;
        end
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        check_results();

        // plain payload, then all ones and all zero
        fill_payload(PAY_MIXED, 4);
        build_frame(16'h0800, 8'h11, PORT, 4, 0);
        send_and_check();
        fill_payload(PAY_ONES, 4);
        build_frame(16'h0800, 8'h11, PORT, 4, 0);
        send_and_check();
        fill_payload(PAY_ZERO, 4);
        build_frame(16'h0800, 8'h11, PORT, 4, 0);
        send_and_check();

        // lengths that are not a multiple of the capacity
        fill_payload(PAY_MIXED, 6);
        build_frame(16'h0800, 8'h11, PORT, 6, 0);
        send_and_check();
        fill_payload(PAY_ZERO, 4);
        build_frame(16'h0800, 8'h11, PORT, 4, 0);
        send_and_check();
        fill_payload(PAY_MIXED, 6);
        build_frame(16'h0800, 8'h11, PORT, 6, 0);
        send_and_check();

        // rejected frames while error is still set
        fill_payload(PAY_MIXED, 4);
        build_frame(16'h86dd, 8'h11, PORT, 4, 0);
        send_and_check();
        build_frame(16'h0800, 8'h06, PORT, 4, 0);
        send_and_check();
        build_frame(16'h0800, 8'h11, PORT + 16'd1, 4, 0);
        send_and_check();
        build_frame(16'h0800, 8'h11, PORT, 4, 0);
        cut_frame(30);
        send_and_check();

        // whole words clear error again
        fill_payload(PAY_MIXED, 8);
        build_frame(16'h0800, 8'h11, PORT, 8, 0);
        send_and_check();

        // short payload, then padding past the declared length
        fill_payload(PAY_MIXED, 2);
        build_frame(16'h0800, 8'h11, PORT, 4, 0);
        send_and_check();
        fill_payload(PAY_MIXED, 4);
        build_frame(16'h0800, 8'h11, PORT, 4, 6);
        send_and_check();

        for (int k = 0; k < N_RANDOM; k++) begin
            kind = $urandom_range(0, 9);
            len  = $urandom_range(1, 12);
            case (kind)
                0: begin
                    fill_payload(PAY_ANY, len);
                    build_frame(16'h0800, 8'h11, PORT + 16'd1, len, 0);
                end
                1: begin
                    fill_payload(PAY_ANY, len);
                    build_frame(16'h0800, 8'h11, PORT, len, 0);
                    cut_frame($urandom_range(1, HDR - 1));
                end
                2: begin
                    fill_payload(PAY_ANY, len);
                    build_frame(16'h0800, 8'h11, PORT, len + $urandom_range(1, 4), 0);
                end
                3: begin
                    fill_payload(PAY_ONES, CAP * $urandom_range(1, 2));
                    build_frame(16'h0800, 8'h11, PORT, pay_q.size(), 0);
                end
                4: begin
                    fill_payload(PAY_ZERO, CAP);
                    build_frame(16'h0800, 8'h11, PORT, CAP, 0);
                end
                default: begin
                    fill_payload(PAY_ANY, len);
                    build_frame(16'h0800, 8'h11, PORT, len, $urandom_range(0, 6));
                end
            endcase
            send_and_check();
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : udp_rx_tb

// ==== udp_rx.f ====
+incdir+logic
logic/udp_rx_pkg.sv
logic/udp_stream_if.sv
logic/udp_header_parser.sv
logic/udp_reader.sv
logic/udp_rx_top.sv
test/udp_rx_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the udp_rx testbench with verilator and runs it
# a $fatal in the testbench gives a nonzero exit status
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal \
        --top-module udp_rx_tb -Mdir obj_dir -o udp_rx_sim \
        -f udp_rx.f &&
    ./obj_dir/udp_rx_sim ||
    { echo "udp_rx simulation did not pass" >&2; exit 1; }
